/* include/chip8_consts.svh */
`ifndef CHIP8_CONSTS_SVH
`define CHIP8_CONSTS_SVH

`define CHIP8_ADDR_W       12
`define CHIP8_DATA_W       8
`define CHIP8_INSTR_W      16
`define CHIP8_I_W          16
`define CHIP8_ALU_OP_W     4
`define CHIP8_APB_ADDR_W   16
`define CHIP8_APB_DATA_W   32
`define CHIP8_VREG_N       16
`define CHIP8_STACK_DEPTH  16
`define CHIP8_RESET_PC     12'h200

// top nibble of each instruction
`define CHIP8_OP_SYS       4'h0
`define CHIP8_OP_JP        4'h1
`define CHIP8_OP_CALL      4'h2
`define CHIP8_OP_SE_BYTE   4'h3
`define CHIP8_OP_SNE_BYTE  4'h4
`define CHIP8_OP_SE_REG    4'h5
`define CHIP8_OP_LD_BYTE   4'h6
`define CHIP8_OP_ADD_BYTE  4'h7
`define CHIP8_OP_ALU       4'h8
`define CHIP8_OP_SNE_REG   4'h9
`define CHIP8_OP_LD_I      4'hA
`define CHIP8_OP_JP_V0     4'hB
`define CHIP8_OP_MISC      4'hF
`define CHIP8_OP_RET       12'h0EE
`define CHIP8_FX_ADD_I     8'h1E

`define CHIP8_ALU_LD       4'h0
`define CHIP8_ALU_OR       4'h1
`define CHIP8_ALU_AND      4'h2
`define CHIP8_ALU_XOR      4'h3
`define CHIP8_ALU_ADD      4'h4
`define CHIP8_ALU_SUB      4'h5
`define CHIP8_ALU_SHR      4'h6
`define CHIP8_ALU_SUBN     4'h7
`define CHIP8_ALU_SHL      4'hE

`define CHIP8_REG_CTRL     16'h1000
`define CHIP8_REG_STATUS   16'h1004
`define CHIP8_REG_V_BASE   16'h1100
`define CHIP8_REG_I        16'h1140

`endif

/* hdl/chip8_pkg.sv */
`include "chip8_consts.svh"

package chip8_pkg;

   typedef logic [`CHIP8_ADDR_W-1:0]          mem_addr_t;
   typedef logic [`CHIP8_DATA_W-1:0]          byte_t;
   typedef logic [$clog2(`CHIP8_VREG_N)-1:0]  vreg_idx_t;
   typedef logic [`CHIP8_I_W-1:0]             i_reg_t;
   typedef logic [`CHIP8_INSTR_W-1:0]         instr_t;
   typedef logic [`CHIP8_ALU_OP_W-1:0]        alu_op_t;
   typedef logic [`CHIP8_APB_ADDR_W-1:0]      apb_addr_t;
   typedef logic [`CHIP8_APB_DATA_W-1:0]      apb_data_t;

   typedef enum logic [2:0]
   {
      IDLE,
      FETCH_HI,
      FETCH_LO,
      EXEC,
      WRITE_FLAG,    // second cycle of the 8xy ops that set VF
      HALTED
   } seq_state_t;

endpackage

/* hdl/chip8_apb_regs.sv */
`timescale 1ns/1ps
`include "chip8_consts.svh"

module chip8_apb_regs
   import chip8_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   input  logic      halted_i,
   input  mem_addr_t pc_i,
   input  byte_t     host_vdata_i,
   input  i_reg_t    i_value_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o,
   output logic      run_o,
   output logic      host_we_o,
   output mem_addr_t host_addr_o,
   output byte_t     host_wdata_o,
   output vreg_idx_t host_vidx_o
);

   logic access;
   logic is_mem;
   logic is_ctrl;
   logic is_status;
   logic is_v;
   logic is_i;
   logic bad;
   logic run_q;

   assign access = psel_i && penable_i;
   assign is_mem = paddr_i < apb_addr_t'(1 << `CHIP8_ADDR_W);
   assign is_ctrl = paddr_i == `CHIP8_REG_CTRL;
   assign is_status = paddr_i == `CHIP8_REG_STATUS;
   assign is_v = (paddr_i >= `CHIP8_REG_V_BASE) &&
                 (paddr_i < `CHIP8_REG_V_BASE + 4 * `CHIP8_VREG_N) &&
                 (paddr_i[1:0] == 2'b00);
   assign is_i = paddr_i == `CHIP8_REG_I;

   always_comb
   begin
      if (is_mem)
         bad = !pwrite_i || run_q;    // program memory is write only, and locked while running
      else if (is_ctrl)
         bad = 1'b0;
      else if (is_status || is_v || is_i)
         bad = pwrite_i;
      else
         bad = 1'b1;
   end

   always_comb
   begin
      prdata_o = '0;
      if (is_ctrl)
         prdata_o = apb_data_t'(run_q);
      else if (is_status)
         prdata_o = apb_data_t'({pc_i, 15'd0, halted_i});    // pc in 27:16
      else if (is_v)
         prdata_o = apb_data_t'(host_vdata_i);
      else if (is_i)
         prdata_o = apb_data_t'(i_value_i);
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         run_q <= 1'b0;
      else if (access && pwrite_i && is_ctrl)
         run_q <= pwdata_i[0];
   end

   assign pready_o = 1'b1;    // zero wait states
   assign pslverr_o = access && bad;
   assign run_o = run_q;
   assign host_we_o = access && pwrite_i && is_mem && !run_q;
   assign host_addr_o = paddr_i[`CHIP8_ADDR_W-1:0];
   assign host_wdata_o = pwdata_i[`CHIP8_DATA_W-1:0];
   assign host_vidx_o = paddr_i[5:2];

endmodule

/* hdl/chip8_prog_mem.sv */
`timescale 1ns/1ps
`include "chip8_consts.svh"

module chip8_prog_mem
   import chip8_pkg::*;
(
   input  logic      clk,
   input  logic      host_we_i,
   input  mem_addr_t host_addr_i,
   input  byte_t     host_wdata_i,
   input  mem_addr_t rd_addr_i,
   output byte_t     rd_data_o
);

   byte_t mem_q [0:(1 << `CHIP8_ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (host_we_i)
         mem_q[host_addr_i] <= host_wdata_i;
      rd_data_o <= mem_q[rd_addr_i];    // one cycle read latency
   end

endmodule

/* hdl/chip8_sequencer.sv */
`timescale 1ns/1ps
`include "chip8_consts.svh"

module chip8_sequencer
   import chip8_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      run_i,
   input  byte_t     rd_data_i,
   input  byte_t     vx_i,
   input  byte_t     vy_i,
   input  byte_t     v0_i,
   input  i_reg_t    i_value_i,
   input  byte_t     alu_result_i,
   input  logic      alu_flag_i,
   input  logic      vx_eq_vy_i,
   input  logic      vx_eq_kk_i,
   output mem_addr_t rd_addr_o,
   output vreg_idx_t vx_idx_o,
   output vreg_idx_t vy_idx_o,
   output alu_op_t   alu_op_o,
   output logic      v_we_o,
   output vreg_idx_t v_widx_o,
   output byte_t     v_wdata_o,
   output logic      i_we_o,
   output i_reg_t    i_wdata_o,
   output logic      halted_o,
   output mem_addr_t pc_o
);

   localparam int SP_W = $clog2(`CHIP8_STACK_DEPTH);

   seq_state_t      state_q;
   mem_addr_t       pc_q;
   mem_addr_t       pc_nxt;
   logic [SP_W-1:0] sp_q;
   logic [SP_W-1:0] sp_nxt;
   mem_addr_t       stack_q [0:`CHIP8_STACK_DEPTH-1];
   byte_t           instr_hi_q;
   logic            flag_q;
   logic            run_q;
   logic            halted_q;
   logic            push;
   logic            is_jump;
   logic            flag_op;
   instr_t          instr;
   mem_addr_t       nnn;
   byte_t           kk;

   assign instr = {instr_hi_q, rd_data_i};    // low byte is on the read port during EXEC
   assign nnn = instr[11:0];
   assign kk = instr[7:0];
   assign vx_idx_o = instr[11:8];
   assign vy_idx_o = instr[7:4];
   assign alu_op_o = instr[3:0];
   assign rd_addr_o = (state_q == FETCH_LO) ? pc_q + mem_addr_t'(1) : pc_q;

   always_comb
   begin
      pc_nxt = pc_q;
      sp_nxt = sp_q;
      push = 1'b0;
      is_jump = 1'b0;
      flag_op = 1'b0;
      v_we_o = 1'b0;
      v_widx_o = instr[11:8];
      v_wdata_o = kk;
      i_we_o = 1'b0;
      i_wdata_o = i_reg_t'(nnn);
      if (state_q == WRITE_FLAG)
      begin
         v_we_o = 1'b1;
         v_widx_o = vreg_idx_t'(`CHIP8_VREG_N - 1);
         v_wdata_o = byte_t'(flag_q);
      end
      else if (state_q == EXEC)
      begin
         pc_nxt = pc_q + mem_addr_t'(2);
         case (instr[15:12])
            `CHIP8_OP_SYS:
               if (nnn == `CHIP8_OP_RET)
               begin
                  sp_nxt = sp_q - 1'b1;
                  pc_nxt = stack_q[sp_nxt];
               end
            `CHIP8_OP_JP:
            begin
               is_jump = 1'b1;
               pc_nxt = nnn;
            end
            `CHIP8_OP_CALL:
            begin
               push = 1'b1;
               sp_nxt = sp_q + 1'b1;
               pc_nxt = nnn;
            end
            `CHIP8_OP_SE_BYTE:
               if (vx_eq_kk_i)
                  pc_nxt = pc_q + mem_addr_t'(4);
            `CHIP8_OP_SNE_BYTE:
               if (!vx_eq_kk_i)
                  pc_nxt = pc_q + mem_addr_t'(4);
            `CHIP8_OP_SE_REG:
               if (instr[3:0] == 4'h0 && vx_eq_vy_i)
                  pc_nxt = pc_q + mem_addr_t'(4);
            `CHIP8_OP_SNE_REG:
               if (instr[3:0] == 4'h0 && !vx_eq_vy_i)
                  pc_nxt = pc_q + mem_addr_t'(4);
            `CHIP8_OP_LD_BYTE:
               v_we_o = 1'b1;
            `CHIP8_OP_ADD_BYTE:
            begin
               v_we_o = 1'b1;
               v_wdata_o = vx_i + kk;    // VF untouched
            end
            `CHIP8_OP_ALU:
            begin
               v_wdata_o = alu_result_i;
               case (alu_op_o)
                  `CHIP8_ALU_LD, `CHIP8_ALU_OR, `CHIP8_ALU_AND, `CHIP8_ALU_XOR:
                     v_we_o = 1'b1;
                  `CHIP8_ALU_ADD, `CHIP8_ALU_SUB, `CHIP8_ALU_SHR,
                  `CHIP8_ALU_SUBN, `CHIP8_ALU_SHL:
                  begin
                     v_we_o = 1'b1;
                     flag_op = 1'b1;
                  end
                  default: ;
               endcase
            end
            `CHIP8_OP_LD_I:
               i_we_o = 1'b1;
            `CHIP8_OP_JP_V0:
            begin
               is_jump = 1'b1;
               pc_nxt = nnn + mem_addr_t'(v0_i);
            end
            `CHIP8_OP_MISC:
               if (kk == `CHIP8_FX_ADD_I)
               begin
                  i_we_o = 1'b1;
                  i_wdata_o = i_value_i + i_reg_t'(vx_i);
               end
            default: ;    // anything else just advances
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q <= IDLE;
         pc_q <= `CHIP8_RESET_PC;
         sp_q <= '0;
         run_q <= 1'b0;
         halted_q <= 1'b0;
      end
      else
      begin
         run_q <= run_i;
         pc_q <= pc_nxt;
         sp_q <= sp_nxt;
         case (state_q)
            IDLE:
               if (run_i && !run_q)    // rising run restarts the program
               begin
                  state_q <= FETCH_HI;
                  pc_q <= `CHIP8_RESET_PC;
                  sp_q <= '0;
                  halted_q <= 1'b0;
               end
            FETCH_HI:
               state_q <= FETCH_LO;
            FETCH_LO:
               state_q <= EXEC;
            EXEC:
               if (is_jump && pc_nxt == pc_q)
               begin
                  state_q <= HALTED;
                  halted_q <= 1'b1;
               end
               else if (flag_op)
                  state_q <= WRITE_FLAG;
               else if (!run_i)
                  state_q <= IDLE;
               else
                  state_q <= FETCH_HI;
            WRITE_FLAG:
               state_q <= run_i ? FETCH_HI : IDLE;
            HALTED:
               if (!run_i)
                  state_q <= IDLE;
            default:
               state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == FETCH_LO)
         instr_hi_q <= rd_data_i;
      if (state_q == EXEC)
         flag_q <= alu_flag_i;
      if (push)
         stack_q[sp_q] <= pc_q + mem_addr_t'(2);    // return to the next instruction
   end

   assign halted_o = halted_q;
   assign pc_o = pc_q;

endmodule

/* hdl/chip8_alu.sv */
`timescale 1ns/1ps
`include "chip8_consts.svh"

module chip8_alu
   import chip8_pkg::*;
(
   input  alu_op_t alu_op_i,
   input  byte_t   vx_i,
   input  byte_t   vy_i,
   input  byte_t   kk_i,
   output byte_t   alu_result_o,
   output logic    alu_flag_o,
   output logic    vx_eq_vy_o,
   output logic    vx_eq_kk_o
);

   logic [`CHIP8_DATA_W:0] sum;

   assign sum = {1'b0, vx_i} + {1'b0, vy_i};

   always_comb
   begin
      alu_result_o = vx_i;
      alu_flag_o = 1'b0;
      case (alu_op_i)
         `CHIP8_ALU_LD:
            alu_result_o = vy_i;
         `CHIP8_ALU_OR:
            alu_result_o = vx_i | vy_i;
         `CHIP8_ALU_AND:
            alu_result_o = vx_i & vy_i;
         `CHIP8_ALU_XOR:
            alu_result_o = vx_i ^ vy_i;
         `CHIP8_ALU_ADD:
         begin
            alu_result_o = sum[`CHIP8_DATA_W-1:0];
            alu_flag_o = sum[`CHIP8_DATA_W];    // carry
         end
         `CHIP8_ALU_SUB:
         begin
            alu_result_o = vx_i - vy_i;
            alu_flag_o = vx_i > vy_i;    // not borrow
         end
         `CHIP8_ALU_SHR:
         begin
            alu_result_o = vx_i >> 1;
            alu_flag_o = vx_i[0];
         end
         `CHIP8_ALU_SUBN:
         begin
            alu_result_o = vy_i - vx_i;
            alu_flag_o = vy_i > vx_i;
         end
         `CHIP8_ALU_SHL:
         begin
            alu_result_o = vx_i << 1;
            alu_flag_o = vx_i[`CHIP8_DATA_W-1];
         end
         default: ;
      endcase
   end

   assign vx_eq_vy_o = vx_i == vy_i;
   assign vx_eq_kk_o = vx_i == kk_i;

endmodule

/* hdl/chip8_regfile.sv */
`timescale 1ns/1ps
`include "chip8_consts.svh"

module chip8_regfile
   import chip8_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  vreg_idx_t vx_idx_i,
   input  vreg_idx_t vy_idx_i,
   input  logic      v_we_i,
   input  vreg_idx_t v_widx_i,
   input  byte_t     v_wdata_i,
   input  logic      i_we_i,
   input  i_reg_t    i_wdata_i,
   input  vreg_idx_t host_vidx_i,
   output byte_t     vx_o,
   output byte_t     vy_o,
   output byte_t     v0_o,
   output i_reg_t    i_value_o,
   output byte_t     host_vdata_o
);

   byte_t  v_q [0:`CHIP8_VREG_N-1];
   i_reg_t i_q;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int n = 0; n < `CHIP8_VREG_N; n++)
            v_q[n] <= '0;
         i_q <= '0;
      end
      else
      begin
         if (v_we_i)
            v_q[v_widx_i] <= v_wdata_i;
         if (i_we_i)
            i_q <= i_wdata_i;
      end
   end

   assign vx_o = v_q[vx_idx_i];
   assign vy_o = v_q[vy_idx_i];
   assign v0_o = v_q[0];    // Bnnn offset
   assign i_value_o = i_q;
   assign host_vdata_o = v_q[host_vidx_i];

endmodule

/* hdl/chip8_top.sv */
`timescale 1ns/1ps

module chip8_top
   import chip8_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   output logic      pslverr_o
);

   logic      run;
   logic      halted;
   mem_addr_t pc;
   logic      host_we;
   mem_addr_t host_addr;
   byte_t     host_wdata;
   vreg_idx_t host_vidx;
   byte_t     host_vdata;
   i_reg_t    i_value;
   mem_addr_t rd_addr;
   byte_t     rd_data;
   vreg_idx_t vx_idx;
   vreg_idx_t vy_idx;
   byte_t     vx;
   byte_t     vy;
   byte_t     v0;
   logic      v_we;
   vreg_idx_t v_widx;
   byte_t     v_wdata;
   logic      i_we;
   i_reg_t    i_wdata;
   alu_op_t   alu_op;
   byte_t     alu_result;
   logic      alu_flag;
   logic      vx_eq_vy;
   logic      vx_eq_kk;

   chip8_apb_regs u_apb_regs (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .halted_i     (halted),
      .pc_i         (pc),
      .host_vdata_i (host_vdata),
      .i_value_i    (i_value),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .run_o        (run),
      .host_we_o    (host_we),
      .host_addr_o  (host_addr),
      .host_wdata_o (host_wdata),
      .host_vidx_o  (host_vidx)
   );

   chip8_prog_mem u_prog_mem (
      .clk          (clk),
      .host_we_i    (host_we),
      .host_addr_i  (host_addr),
      .host_wdata_i (host_wdata),
      .rd_addr_i    (rd_addr),
      .rd_data_o    (rd_data)
   );

   chip8_sequencer u_sequencer (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .run_i        (run),
      .rd_data_i    (rd_data),
      .vx_i         (vx),
      .vy_i         (vy),
      .v0_i         (v0),
      .i_value_i    (i_value),
      .alu_result_i (alu_result),
      .alu_flag_i   (alu_flag),
      .vx_eq_vy_i   (vx_eq_vy),
      .vx_eq_kk_i   (vx_eq_kk),
      .rd_addr_o    (rd_addr),
      .vx_idx_o     (vx_idx),
      .vy_idx_o     (vy_idx),
      .alu_op_o     (alu_op),
      .v_we_o       (v_we),
      .v_widx_o     (v_widx),
      .v_wdata_o    (v_wdata),
      .i_we_o       (i_we),
      .i_wdata_o    (i_wdata),
      .halted_o     (halted),
      .pc_o         (pc)
   );

   chip8_alu u_alu (
      .alu_op_i     (alu_op),
      .vx_i         (vx),
      .vy_i         (vy),
      .kk_i         (rd_data),    // low instruction byte during EXEC
      .alu_result_o (alu_result),
      .alu_flag_o   (alu_flag),
      .vx_eq_vy_o   (vx_eq_vy),
      .vx_eq_kk_o   (vx_eq_kk)
   );

   chip8_regfile u_regfile (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .vx_idx_i     (vx_idx),
      .vy_idx_i     (vy_idx),
      .v_we_i       (v_we),
      .v_widx_i     (v_widx),
      .v_wdata_i    (v_wdata),
      .i_we_i       (i_we),
      .i_wdata_i    (i_wdata),
      .host_vidx_i  (host_vidx),
      .vx_o         (vx),
      .vy_o         (vy),
      .v0_o         (v0),
      .i_value_o    (i_value),
      .host_vdata_o (host_vdata)
   );

endmodule

/* sim/tb_chip8.sv */
`timescale 1ns/1ps

module tb_chip8;

   localparam logic [15:0] CTRL_ADDR = 16'h1000;
   localparam logic [15:0] STATUS_ADDR = 16'h1004;
   localparam logic [15:0] V_BASE_ADDR = 16'h1100;
   localparam logic [15:0] I_ADDR = 16'h1140;
   localparam logic [11:0] START_PC = 12'h200;
   localparam int READY_LIMIT = 16;
   localparam int POLL_LIMIT = 2000;

   logic        clk;
   logic        rst_n_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [15:0] paddr_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;

   logic [15:0] prog [$];
   int          errors;
   int          errors_at_start;
   int          tests_run;
   int          tests_failed;
   int unsigned seed_word;

   chip8_top DUT (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o)
   );

   always #5 clk = ~clk;

   function automatic logic [7:0] rand_byte();
      return 8'($urandom);
   endfunction

   function automatic logic [3:0] rand_vreg();
      return 4'($urandom % 15);    // never VF
   endfunction

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int waits;
      @(posedge clk);
      psel_i <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i <= wr;
      paddr_i <= addr;
      pwdata_i <= wdata;
      @(posedge clk);
      penable_i <= 1'b1;
      waits = 0;
      @(negedge clk);
      while (!pready_o && waits < READY_LIMIT)
      begin
         @(negedge clk);
         waits++;
      end
      if (!pready_o)
      begin
         $display("APB slave never raised pready at address 0x%0h", addr);
         errors++;
      end
      rdata = prdata_o;    // stable mid access phase
      err = pslverr_o;
      @(posedge clk);
      psel_i <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic apb_write(input logic [15:0] addr, input logic [31:0] data, output logic err);
      logic [31:0] rd_ignored;
      apb_access(1'b1, addr, data, rd_ignored, err);
   endtask

   task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
      apb_access(1'b0, addr, 32'd0, data, err);
   endtask

   task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
      logic err;
      apb_write(addr, data, err);
      compare_value("pslverr_o", {31'd0, err}, 32'd0);
   endtask

   task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
      logic err;
      apb_read(addr, data, err);
      compare_value("pslverr_o", {31'd0, err}, 32'd0);
   endtask

   task automatic load_program();
      logic [15:0] addr;
      host_write(CTRL_ADDR, 32'd0);    // stop so memory accepts writes
      foreach (prog[n])
      begin
         addr = {4'h0, START_PC} + 16'(2 * n);
         host_write(addr, {24'd0, prog[n][15:8]});
         host_write(addr + 16'd1, {24'd0, prog[n][7:0]});
      end
   endtask

   task automatic start_core();
      host_write(CTRL_ADDR, 32'd1);
   endtask

   task automatic run_until_halt(output logic [11:0] pc);
      logic [31:0] status;
      int polls;
      polls = 0;
      read_reg(STATUS_ADDR, status);
      while (!status[0] && polls < POLL_LIMIT)
      begin
         read_reg(STATUS_ADDR, status);
         polls++;
      end
      if (!status[0])
      begin
         $display("core did not halt within %0d status polls", POLL_LIMIT);
         errors++;
      end
      pc = status[27:16];
   endtask

   task automatic check_v(input int n, input logic [7:0] exp);
      logic [31:0] data;
      read_reg(V_BASE_ADDR + 16'(4 * n), data);
      compare_value($sformatf("V%0h", n), data, {24'd0, exp});
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors != errors_at_start)
         tests_failed++;
      $display("test %s: %s", name, (errors == errors_at_start) ? "ok" : "failed");
   endtask

   task automatic test_add_halt();
      logic [7:0]  k0;
      logic [7:0]  k1;
      logic [7:0]  k2;
      logic [7:0]  kf;
      logic [7:0]  exp_sum;
      logic [3:0]  x;
      logic [11:0] pc;
      logic [31:0] status;
      errors_at_start = errors;
      read_reg(STATUS_ADDR, status);
      compare_value("status", status, 32'h0200_0000);    // out of reset
      x = rand_vreg();
      k0 = rand_byte();
      k1 = rand_byte();
      k2 = rand_byte();
      kf = rand_byte();
      exp_sum = k0 + k1 + k2;
      prog.delete();
      prog.push_back({8'h6F, kf});
      prog.push_back({4'h6, x, k0});
      prog.push_back({4'h7, x, k1});
      prog.push_back({4'h7, x, k2});
      prog.push_back(16'h1208);
      load_program();
      start_core();
      run_until_halt(pc);
      compare_value("pc", {20'd0, pc}, 32'h208);
      check_v(x, exp_sum);
      check_v(15, kf);    // add byte leaves VF alone
      finish_test("add_halt");
   endtask

   task automatic test_alu();
      logic [3:0]  ops [0:8];
      logic [7:0]  a;
      logic [7:0]  b;
      logic [7:0]  m;
      logic [7:0]  exp_r;
      logic [7:0]  exp_f;
      logic [8:0]  wide;
      logic [11:0] pc;
      errors_at_start = errors;
      ops = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
      for (int i = 0; i < 9; i++)
      begin
         a = rand_byte();
         b = rand_byte();
         m = rand_byte();
         exp_f = m;
         case (ops[i])
            4'h0: exp_r = b;
            4'h1: exp_r = a | b;
            4'h2: exp_r = a & b;
            4'h3: exp_r = a ^ b;
            4'h4:
            begin
               wide = {1'b0, a} + {1'b0, b};
               exp_r = wide[7:0];
               exp_f = {7'd0, wide[8]};
            end
            4'h5:
            begin
               exp_r = a - b;
               exp_f = {7'd0, a > b};
            end
            4'h6:
            begin
               exp_r = a >> 1;
               exp_f = {7'd0, a[0]};
            end
            4'h7:
            begin
               exp_r = b - a;
               exp_f = {7'd0, b > a};
            end
            default:
            begin
               exp_r = a << 1;
               exp_f = {7'd0, a[7]};
            end
         endcase
         prog.delete();
         prog.push_back({8'h6F, m});
         prog.push_back({8'h61, a});
         prog.push_back({8'h62, b});
         prog.push_back({8'h81, 4'h2, ops[i]});
         prog.push_back(16'h1208);
         load_program();
         start_core();
         run_until_halt(pc);
         compare_value("pc", {20'd0, pc}, 32'h208);
         check_v(1, exp_r);
         check_v(15, exp_f);
      end
      finish_test("alu_ops");
   endtask

   task automatic test_skips();
      logic [15:0] skips [0:7];
      logic        taken [0:7];
      logic [7:0]  a;
      logic [7:0]  b;
      logic [11:0] halt_pc;
      logic [11:0] pc;
      errors_at_start = errors;
      a = rand_byte();
      b = a ^ (rand_byte() | 8'h01);    // always differs from a
      // V1 = V2 = a, V3 = b
      skips = '{{8'h31, a}, {8'h31, b}, {8'h41, a}, {8'h41, b},
                16'h5120, 16'h5130, 16'h9120, 16'h9130};
      taken = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
      prog.delete();
      prog.push_back({8'h61, a});
      prog.push_back({8'h62, a});
      prog.push_back({8'h63, b});
      for (int i = 0; i < 8; i++)
         prog.push_back({4'h6, 4'(4 + i), 8'h00});    // clear markers
      for (int i = 0; i < 8; i++)
      begin
         prog.push_back(skips[i]);
         prog.push_back({4'h6, 4'(4 + i), 8'h01});
      end
      halt_pc = START_PC + 12'(2 * prog.size());
      prog.push_back({4'h1, halt_pc});
      load_program();
      start_core();
      run_until_halt(pc);
      compare_value("pc", {20'd0, pc}, {20'd0, halt_pc});
      for (int i = 0; i < 8; i++)
         check_v(4 + i, taken[i] ? 8'h00 : 8'h01);
      finish_test("skips");
   endtask

   task automatic test_call_jump();
      logic [7:0]  k1;
      logic [7:0]  k2;
      logic [11:0] pc;
      errors_at_start = errors;
      k1 = rand_byte();
      k2 = rand_byte();
      prog.delete();
      prog.push_back(16'h6300);
      prog.push_back(16'h6004);
      prog.push_back(16'h220E);    // call subroutine at 20E
      prog.push_back({8'h62, k2});
      prog.push_back(16'hB20E);    // 20E + V0 lands on the halt
      prog.push_back(16'h63A5);
      prog.push_back(16'h120C);
      prog.push_back({8'h61, k1});
      prog.push_back(16'h00EE);
      prog.push_back(16'h1212);
      load_program();
      start_core();
      run_until_halt(pc);
      compare_value("pc", {20'd0, pc}, 32'h212);
      check_v(0, 8'h04);
      check_v(1, k1);
      check_v(2, k2);
      check_v(3, 8'h00);
      finish_test("call_return_jump");
   endtask

   task automatic test_i_reg();
      logic [11:0] nnn;
      logic [7:0]  k;
      logic [3:0]  x;
      logic [15:0] exp_i;
      logic [31:0] data;
      logic [11:0] pc;
      errors_at_start = errors;
      nnn = 12'($urandom);
      k = rand_byte();
      x = rand_vreg();
      exp_i = {4'h0, nnn} + {8'h00, k};
      prog.delete();
      prog.push_back({4'hA, nnn});
      prog.push_back({4'h6, x, k});
      prog.push_back({4'hF, x, 8'h1E});
      prog.push_back(16'h1206);
      load_program();
      start_core();
      run_until_halt(pc);
      compare_value("pc", {20'd0, pc}, 32'h206);
      read_reg(I_ADDR, data);
      compare_value("I", data, {16'd0, exp_i});
      finish_test("i_register");
   endtask

   task automatic test_apb_errors();
      logic [7:0]  k;
      logic [31:0] data;
      logic        err;
      logic [11:0] pc;
      errors_at_start = errors;
      k = rand_byte();
      prog.delete();
      prog.push_back(16'h6100);
      prog.push_back(16'h7101);    // 256 passes round this loop
      prog.push_back(16'h3100);
      prog.push_back(16'h1202);
      prog.push_back({8'h6A, k});
      prog.push_back(16'h120A);
      load_program();
      start_core();
      apb_write(16'h0209, {24'd0, ~k}, err);
      compare_value("pslverr_o", {31'd0, err}, 32'd1);
      apb_read(16'h2000, data, err);
      compare_value("pslverr_o", {31'd0, err}, 32'd1);
      compare_value("prdata_o", data, 32'd0);
      apb_write(16'h1008, 32'hFFFF_FFFF, err);
      compare_value("pslverr_o", {31'd0, err}, 32'd1);
      run_until_halt(pc);
      compare_value("pc", {20'd0, pc}, 32'h20A);
      check_v(1, 8'h00);
      check_v(10, k);
      finish_test("apb_errors");
   endtask

   initial
   begin
      clk = 1'b0;
      rst_n_i = 1'b0;
      psel_i = 1'b0;
      penable_i = 1'b0;
      pwrite_i = 1'b0;
      paddr_i = '0;
      pwdata_i = '0;
      errors = 0;
      errors_at_start = 0;
      tests_run = 0;
      tests_failed = 0;
      seed_word = $urandom(68639);
      repeat (8) @(posedge clk);
      rst_n_i <= 1'b1;
      test_add_halt();
      test_alu();
      test_skips();
      test_call_jump();
      test_i_reg();
      test_apb_errors();
      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* project.f */
+incdir+include
hdl/chip8_pkg.sv
hdl/chip8_apb_regs.sv
hdl/chip8_prog_mem.sv
hdl/chip8_sequencer.sv
hdl/chip8_alu.sv
hdl/chip8_regfile.sv
hdl/chip8_top.sv
sim/tb_chip8.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing -Wno-fatal -f project.f --top-module tb_chip8 -o tb_chip8 \
   && ./obj_dir/tb_chip8 > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
   || echo "simulation finished without failure"
